// ==== alignPkg.sv ====
`default_nettype none

package alignPkg;

    // ##################################################################
    // sample format
    // ##################################################################

    localparam int SAMPLE_WIDTH = 18;

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] re;
        logic signed [SAMPLE_WIDTH-1:0] im;
    } complexSample;

    // ##################################################################
    // frame layout
    // ##################################################################

    localparam int SAMPLES_PER_FRAME = 64;
    localparam int PILOT_SAMPLES_PER_FRAME = 16;

    // payload keeps a few samples from the tail of the pilot
    localparam int PAYLOAD_LEAD = 4;

    localparam int FRAME_COUNT_WIDTH = 15;

endpackage

`default_nettype wire

// ==== sampleBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface sampleBus
    import alignPkg::*;
();

    // start and valid only count while clkEn is high
    logic         clkEn;
    logic         start;
    logic         valid;
    complexSample sample;

    modport source (
        output clkEn,
        output start,
        output valid,
        output sample
    );

    modport sink (
        input clkEn,
        input start,
        input valid,
        input sample
    );

endinterface

`default_nettype wire

// ==== alignedBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface alignedBus
    import alignPkg::*;
();

    // one-cycle pulse, other fields qualified by it
    logic         strobe;
    logic         interpolate;
    complexSample sample;

    modport source (
        output strobe,
        output interpolate,
        output sample
    );

    modport sink (
        input strobe,
        input interpolate,
        input sample
    );

endinterface

`default_nettype wire

// ==== laneDispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module laneDispatcher
    import alignPkg::*;
#(
    parameter int NUM_LANES = 4,
    localparam int LANE_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    clkEn,
    input  wire                    start,
    input  wire                    valid,
    input  wire [LANE_WIDTH-1:0]   lane,
    input  wire complexSample      din,
    sampleBus.source               lanes[NUM_LANES]
);

    logic [NUM_LANES-1:0] laneHit;
    logic [NUM_LANES-1:0] startVec;
    logic [NUM_LANES-1:0] validVec;
    logic                 clkEnReg;
    complexSample         sampleReg;

    // one-hot lane decode
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            laneHit[i] = (lane == LANE_WIDTH'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            clkEnReg <= 1'b0;
            startVec <= '0;
            validVec <= '0;
        end else begin
            clkEnReg <= clkEn;
            startVec <= start ? laneHit : '0;
            validVec <= valid ? laneHit : '0;
        end
    end

    always_ff @(posedge clk) begin
        sampleReg <= din;
    end

    // enable and sample go to every lane
    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        assign lanes[i].clkEn  = clkEnReg;
        assign lanes[i].start  = startVec[i];
        assign lanes[i].valid  = validVec[i];
        assign lanes[i].sample = sampleReg;
    end

endmodule

`default_nettype wire

// ==== sampleFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sampleFifo
    import alignPkg::*;
#(
    parameter int DEPTH = 64,
    localparam int PTR_WIDTH = $clog2(DEPTH)
) (
    input  wire                clk,
    input  wire                reset,
    input  wire                flush,
    input  wire                wrEn,
    input  wire complexSample  din,
    input  wire                rdEn,
    output complexSample       head,
    output logic               headValid
);

    localparam logic [PTR_WIDTH:0] FULL_COUNT = (PTR_WIDTH+1)'(DEPTH);

    complexSample          mem [DEPTH];
    logic [PTR_WIDTH-1:0]  wrPtr;
    logic [PTR_WIDTH-1:0]  rdPtr;
    logic [PTR_WIDTH:0]    count;
    logic                  doWrite;
    logic                  doRead;

    assign doRead  = rdEn && (count != '0);
    // full fifo still takes a write when the head leaves in the same cycle
    assign doWrite = wrEn && ((count != FULL_COUNT) || doRead);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= din;
        end
    end

    // first word falls through
    assign head      = mem[rdPtr];
    assign headValid = (count != '0);

endmodule

`default_nettype wire

// ==== frameAlignment.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameAlignment
    import alignPkg::*;
#(
    parameter int START_OFFSET    = 0,
    parameter int CLKS_PER_OUTPUT = 4,
    parameter int FIFO_DEPTH      = 64
) (
    input  wire        clk,
    input  wire        reset,
    sampleBus.sink     in,
    alignedBus.source  out
);

    localparam int WINDOW_LO = PILOT_SAMPLES_PER_FRAME - PAYLOAD_LEAD;

    localparam logic WAIT_DATA = 1'b0;
    localparam logic DECIMATE  = 1'b1;

    // hold-off length after the strobe cycle itself
    localparam logic [2:0] DECIM_START =
        (CLKS_PER_OUTPUT > 1) ? 3'(CLKS_PER_OUTPUT - 2) : 3'd0;

    logic                          enabledStart;
    logic                          enabledValid;
    logic                          frameOpen;
    logic [FRAME_COUNT_WIDTH-1:0]  sampleCount;
    logic                          inWindow;
    logic                          fifoWrEn;
    complexSample                  fifoHead;
    logic                          fifoHeadValid;
    logic                          outState;
    logic                          readReg;
    logic [2:0]                    decimCount;
    logic [1:0]                    outCount;
    logic                          strobe;

    // start wins over valid
    assign enabledStart = in.clkEn && in.start;
    assign enabledValid = in.clkEn && in.valid && !in.start;

    // ##################################################################
    // sample counter
    // ##################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            frameOpen   <= 1'b0;
            sampleCount <= '0;
        end else if (enabledStart) begin
            frameOpen   <= 1'b1;
            sampleCount <= FRAME_COUNT_WIDTH'(START_OFFSET);
        end else if (enabledValid && frameOpen) begin
            sampleCount <= sampleCount + 1'b1;
            if (int'(sampleCount) >= SAMPLES_PER_FRAME - 1) begin
                frameOpen <= 1'b0;
            end
        end
    end

    assign inWindow = (int'(sampleCount) >= WINDOW_LO) &&
                      (int'(sampleCount) < SAMPLES_PER_FRAME);
    assign fifoWrEn = enabledValid && frameOpen && inWindow;

    // ##################################################################
    // payload buffer
    // ##################################################################

    // a new start throws away whatever is left of the last frame
    sampleFifo #(
        .DEPTH(FIFO_DEPTH)
    ) i_fifo (
        .clk      (clk),
        .reset    (reset),
        .flush    (enabledStart),
        .wrEn     (fifoWrEn),
        .din      (in.sample),
        .rdEn     (strobe),
        .head     (fifoHead),
        .headValid(fifoHeadValid)
    );

    // ##################################################################
    // output pacing
    // ##################################################################

    assign strobe = readReg && fifoHeadValid && in.clkEn && !in.start;

    always_ff @(posedge clk) begin
        if (reset || enabledStart) begin
            outState   <= WAIT_DATA;
            readReg    <= 1'b0;
            decimCount <= '0;
            outCount   <= '0;
        end else if (in.clkEn) begin
            if (strobe) begin
                outCount <= outCount + 1'b1;
            end
            case (outState)
                WAIT_DATA: begin
                    readReg <= fifoHeadValid;
                    if (fifoHeadValid && (CLKS_PER_OUTPUT > 1)) begin
                        outState   <= DECIMATE;
                        decimCount <= DECIM_START;
                    end
                end
                DECIMATE: begin
                    readReg <= 1'b0;
                    if (decimCount == '0) begin
                        outState <= WAIT_DATA;
                    end else begin
                        decimCount <= decimCount - 1'b1;
                    end
                end
            endcase
        end
    end

    // every fourth output of the frame goes to the interpolator
    assign out.strobe      = strobe;
    assign out.interpolate = (outCount == 2'd3);
    assign out.sample      = fifoHead;

endmodule

`default_nettype wire

// ==== laneCollector.sv ====
`timescale 1ns/1ps
`default_nettype none

module laneCollector
    import alignPkg::*;
#(
    parameter int NUM_LANES = 4,
    localparam int LANE_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  wire                    clk,
    input  wire                    reset,
    alignedBus.sink                lanes[NUM_LANES],
    output logic                   outValid,
    output logic [LANE_WIDTH-1:0]  outLane,
    output complexSample           dout,
    output logic                   outInterpolate,
    output logic                   overflow
);

    logic [NUM_LANES-1:0]   laneStrobe;
    logic [NUM_LANES-1:0]   laneInterp;
    complexSample           laneSample [NUM_LANES];
    logic [NUM_LANES-1:0]   pending;
    logic [NUM_LANES-1:0]   holdInterp;
    complexSample           holdSample [NUM_LANES];
    logic [LANE_WIDTH-1:0]  rrPtr;
    logic [LANE_WIDTH-1:0]  nextPtr;
    logic [LANE_WIDTH-1:0]  sel;
    logic [NUM_LANES-1:0]   grant;
    logic                   found;

    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        assign laneStrobe[i] = lanes[i].strobe;
        assign laneInterp[i] = lanes[i].interpolate;
        assign laneSample[i] = lanes[i].sample;
    end

    // ##################################################################
    // round-robin pick
    // ##################################################################

    always_comb begin
        int idx;
        found = 1'b0;
        sel   = '0;
        grant = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = (int'(rrPtr) + k) % NUM_LANES;
            if (!found && pending[idx]) begin
                found = 1'b1;
                sel   = LANE_WIDTH'(idx);
            end
        end
        if (found) begin
            grant[sel] = 1'b1;
        end
    end

    assign nextPtr = (int'(sel) == NUM_LANES - 1) ? '0 : sel + 1'b1;

    // ##################################################################
    // holding and drain
    // ##################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            pending  <= '0;
            rrPtr    <= '0;
            outValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            pending  <= laneStrobe | (pending & ~grant);
            outValid <= found;
            if (found) begin
                rrPtr <= nextPtr;
            end
            // lane still full and not drained this cycle
            if (|(laneStrobe & pending & ~grant)) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (laneStrobe[i]) begin
                holdSample[i] <= laneSample[i];
                holdInterp[i] <= laneInterp[i];
            end
        end
        if (found) begin
            outLane        <= sel;
            dout           <= holdSample[sel];
            outInterpolate <= holdInterp[sel];
        end
    end

endmodule

`default_nettype wire

// ==== frameAlignTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameAlignTop
    import alignPkg::*;
#(
    parameter int NUM_LANES       = 4,
    parameter int CLKS_PER_OUTPUT = 4,
    parameter int START_OFFSET    = 0,
    parameter int FIFO_DEPTH      = 64,
    localparam int LANE_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    clkEn,
    input  wire                    start,
    input  wire                    valid,
    input  wire [LANE_WIDTH-1:0]   lane,
    input  wire complexSample      din,
    output logic                   outValid,
    output logic [LANE_WIDTH-1:0]  outLane,
    output complexSample           dout,
    output logic                   outInterpolate,
    output logic                   overflow
);

    sampleBus  laneIn  [NUM_LANES] ();
    alignedBus laneOut [NUM_LANES] ();

    laneDispatcher #(
        .NUM_LANES(NUM_LANES)
    ) i_dispatcher (
        .clk  (clk),
        .reset(reset),
        .clkEn(clkEn),
        .start(start),
        .valid(valid),
        .lane (lane),
        .din  (din),
        .lanes(laneIn)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : gAligner
        frameAlignment #(
            .START_OFFSET   (START_OFFSET),
            .CLKS_PER_OUTPUT(CLKS_PER_OUTPUT),
            .FIFO_DEPTH     (FIFO_DEPTH)
        ) i_aligner (
            .clk  (clk),
            .reset(reset),
            .in   (laneIn[i]),
            .out  (laneOut[i])
        );
    end

    laneCollector #(
        .NUM_LANES(NUM_LANES)
    ) i_collector (
        .clk           (clk),
        .reset         (reset),
        .lanes         (laneOut),
        .outValid      (outValid),
        .outLane       (outLane),
        .dout          (dout),
        .outInterpolate(outInterpolate),
        .overflow      (overflow)
    );

endmodule

`default_nettype wire

// ==== alignCheck_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module alignCheck_props #(
    parameter int NUM_LANES       = 4,
    parameter int CLKS_PER_OUTPUT = 4
) (
    input wire                 clk,
    input wire                 reset,
    input wire                 outValid,
    input wire                 overflow,
    input wire                 laneClkEn,
    input wire [NUM_LANES-1:0] laneStrobe
);

    // enabled clocks since a lane's last strobe, saturating
    logic [3:0] sinceStrobe [NUM_LANES];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (reset) begin
                sinceStrobe[i] <= 4'(CLKS_PER_OUTPUT);
            end else if (laneStrobe[i]) begin
                sinceStrobe[i] <= '0;
            end else if (laneClkEn && (int'(sinceStrobe[i]) < CLKS_PER_OUTPUT)) begin
                sinceStrobe[i] <= sinceStrobe[i] + 1'b1;
            end
        end
    end

    noOverflow: assert property (@(posedge clk) disable iff (reset) !overflow)
        else $error("collector overflow flag went high");

    quietInReset: assert property (@(posedge clk) reset |=> !outValid)
        else $error("outValid high while reset was asserted");

    // strobe cycle itself counts as one enabled clock
    for (genvar i = 0; i < NUM_LANES; i++) begin : gPacing
        strobeSpacing: assert property (@(posedge clk) disable iff (reset)
            laneStrobe[i] |-> (int'(sinceStrobe[i]) >= CLKS_PER_OUTPUT - 1))
            else $error("lane %0d strobes closer than %0d enabled clocks", i, CLKS_PER_OUTPUT);
    end

endmodule

`default_nettype wire

// ==== frameAlignTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frameAlignTb
    import alignPkg::*;
();

    localparam int NUM_LANES       = 4;
    localparam int CLKS_PER_OUTPUT = 4;
    localparam int START_OFFSET    = 0;
    localparam int FIFO_DEPTH      = 64;
    localparam int LANE_WIDTH      = $clog2(NUM_LANES);
    localparam int WINDOW_LO       = PILOT_SAMPLES_PER_FRAME - PAYLOAD_LEAD;
    localparam int NUM_ROWS        = 7;
    localparam int STALE_CYCLES    = NUM_LANES + 6;
    localparam int SETTLE_SLOTS    = 24;
    // a full fifo drained at the output rate
    localparam int DRAIN_SLOTS     = FIFO_DEPTH * CLKS_PER_OUTPUT + NUM_LANES;

    typedef struct {
        int firstLane;
        int laneCount;
        int samples;
        int duty;
        int gap;
        int cutAt;
    } burstRow;

    logic                  clk;
    logic                  reset;
    logic                  clkEn;
    logic                  start;
    logic                  valid;
    logic [LANE_WIDTH-1:0] lane;
    complexSample          din;
    logic                  outValid;
    logic [LANE_WIDTH-1:0] outLane;
    complexSample          dout;
    logic                  outInterpolate;
    logic                  overflow;

    burstRow     rows [NUM_ROWS];
    // {interpolate, sample} per expected output
    logic [36:0] expQ [NUM_LANES][$];
    logic [36:0] staleQ [NUM_LANES][$];
    int          laneCnt [NUM_LANES];
    bit          laneOpen [NUM_LANES];
    int          outIdx [NUM_LANES];
    int          startCycle [NUM_LANES];
    int          cycleNo;
    int unsigned rngState = 7;
    int          mismatchCount;
    int          otherErrors;

    frameAlignTop #(
        .NUM_LANES      (NUM_LANES),
        .CLKS_PER_OUTPUT(CLKS_PER_OUTPUT),
        .START_OFFSET   (START_OFFSET),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) i_frameAlignTop (
        .clk           (clk),
        .reset         (reset),
        .clkEn         (clkEn),
        .start         (start),
        .valid         (valid),
        .lane          (lane),
        .din           (din),
        .outValid      (outValid),
        .outLane       (outLane),
        .dout          (dout),
        .outInterpolate(outInterpolate),
        .overflow      (overflow)
    );

    bind frameAlignTop alignCheck_props #(
        .NUM_LANES      (NUM_LANES),
        .CLKS_PER_OUTPUT(CLKS_PER_OUTPUT)
    ) i_props (
        .clk       (clk),
        .reset     (reset),
        .outValid  (outValid),
        .overflow  (overflow),
        .laneClkEn (i_dispatcher.clkEnReg),
        .laneStrobe(i_collector.laneStrobe)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleNo <= cycleNo + 1;
    end

    // ####################################################################
    // reference model
    // ####################################################################

    function automatic int unsigned nextRand();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return rngState;
    endfunction

    function automatic void modelInput(int ln, bit st, bit vl, complexSample smp);
        logic interp;
        if (st) begin
            // whatever was queued belongs to the old frame now
            staleQ[ln] = expQ[ln];
            expQ[ln].delete();
            laneOpen[ln] = 1'b1;
            laneCnt[ln] = START_OFFSET;
            outIdx[ln] = 0;
            startCycle[ln] = cycleNo;
        end else if (vl && laneOpen[ln]) begin
            if (laneCnt[ln] >= WINDOW_LO && laneCnt[ln] < SAMPLES_PER_FRAME) begin
                interp = (outIdx[ln] % 4 == 3);
                expQ[ln].push_back({interp, smp});
                outIdx[ln]++;
            end
            laneCnt[ln]++;
            if (laneCnt[ln] >= SAMPLES_PER_FRAME) begin
                laneOpen[ln] = 1'b0;
            end
        end
    endfunction

    function automatic int pendingCount();
        int total;
        total = 0;
        for (int ln = 0; ln < NUM_LANES; ln++) begin
            total += expQ[ln].size();
        end
        return total;
    endfunction

    function automatic void reportLeftovers();
        for (int ln = 0; ln < NUM_LANES; ln++) begin
            if (expQ[ln].size() != 0) begin
                $display("lane %0d never produced %0d expected outputs", ln, expQ[ln].size());
                otherErrors++;
                expQ[ln].delete();
            end
        end
    endfunction

    task automatic compareValue(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            mismatchCount++;
        end
    endtask

    task automatic checkOutput();
        int          ln;
        logic [36:0] expected;
        ln = int'(outLane);
        // last outputs of a restarted frame can still be on their way
        if (staleQ[ln].size() != 0 && (cycleNo - startCycle[ln]) <= STALE_CYCLES &&
                {outInterpolate, dout} === staleQ[ln][0]) begin
            void'(staleQ[ln].pop_front());
        end else begin
            staleQ[ln].delete();
            if (expQ[ln].size() == 0) begin
                $display("output on lane %0d at %0t while nothing was expected", ln, $time);
                otherErrors++;
            end else begin
                expected = expQ[ln].pop_front();
                compareValue("dout", 64'(dout), 64'(expected[35:0]));
                compareValue("outInterpolate", 64'(outInterpolate), 64'(expected[36]));
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset && outValid) begin
            checkOutput();
        end
    end

    // ####################################################################
    // stimulus
    // ####################################################################

    task automatic driveSlot(int ln, bit st, bit vl, int duty);
        int unsigned  r;
        complexSample smp;
        if (duty == 2) begin
            // junk in a disabled cycle, lanes must ignore it
            r = nextRand();
            @(posedge clk);
            clkEn <= 1'b0;
            start <= r[20];
            valid <= 1'b1;
            lane  <= LANE_WIDTH'(ln);
            din   <= {r[17:0], r[31:14]};
        end
        r = nextRand();
        smp.re = r[26:9];
        r = nextRand();
        smp.im = r[26:9];
        @(posedge clk);
        clkEn <= 1'b1;
        start <= st;
        valid <= vl;
        lane  <= LANE_WIDTH'(ln);
        din   <= smp;
        modelInput(ln, st, vl, smp);
    endtask

    task automatic applyRow(int idx);
        burstRow r;
        int      ln;
        int      waited;
        r = rows[idx];
        for (int k = 0; k < r.laneCount; k++) begin
            driveSlot((r.firstLane + k) % NUM_LANES, 1'b1, 1'b0, r.duty);
        end
        for (int s = 0; s < r.samples; s++) begin
            if (r.cutAt != 0 && s == r.cutAt) begin
                driveSlot(r.firstLane, 1'b1, 1'b0, r.duty);
            end
            for (int k = 0; k < r.laneCount; k++) begin
                ln = (r.firstLane + k) % NUM_LANES;
                driveSlot(ln, 1'b0, 1'b1, r.duty);
                repeat (r.gap) driveSlot(ln, 1'b0, 1'b0, r.duty);
            end
        end
        waited = 0;
        while (pendingCount() != 0 && waited < DRAIN_SLOTS) begin
            driveSlot(0, 1'b0, 1'b0, r.duty);
            waited++;
        end
        // anything arriving now is beyond the frame
        repeat (SETTLE_SLOTS) driveSlot(0, 1'b0, 1'b0, r.duty);
        reportLeftovers();
    endtask

    function automatic void loadTable();
        // first lane, lanes, samples, duty, gap, restart after
        rows[0] = '{0, 1, 64, 1, 0, 0};
        rows[1] = '{1, 1, 72, 1, 1, 0};
        rows[2] = '{2, 1, 64, 2, 0, 0};
        rows[3] = '{3, 1, 64, 1, 0, 24};
        rows[4] = '{0, 4, 64, 1, 0, 0};
        rows[5] = '{1, 4, 66, 2, 1, 30};
        rows[6] = '{2, 1, 40, 1, 2, 0};
    endfunction

    function automatic int watchdogCycles();
        int total;
        int slots;
        total = 500;
        for (int i = 0; i < NUM_ROWS; i++) begin
            slots = rows[i].laneCount * (rows[i].samples * (rows[i].gap + 1) + 1);
            slots += 1 + DRAIN_SLOTS + SETTLE_SLOTS;
            total += slots * rows[i].duty * CLKS_PER_OUTPUT + 200;
        end
        return total;
    endfunction

    initial begin
        int limit;
        @(negedge reset);
        limit = watchdogCycles();
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clkEn = 1'b0;
        start = 1'b0;
        valid = 1'b0;
        lane  = '0;
        din   = '0;
        reset = 1'b1;
        loadTable();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            applyRow(i);
        end
        // sticky flag, one look at the end covers the whole run
        compareValue("overflow", 64'(overflow), 64'(1'b0));
        $display("errors: %0d value mismatches, %0d other", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
alignPkg.sv
sampleBus.sv
alignedBus.sv
laneDispatcher.sv
sampleFifo.sv
frameAlignment.sv
laneCollector.sv
frameAlignTop.sv
alignCheck_props.sv
frameAlignTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := frameAlignTb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
